// ==== source/bitalign_eye_scan.sv ====
`timescale 1ns/1ps
`include "bitalign_params.svh"

module bitalign_eye_scan
   import bitalign_pkg::*;
(
   input  logic       sclk,
   input  logic       arst_n,
   input  logic       start,
   input  logic       rstrt,
   input  logic       hold,
   input  logic       skip,
   input  logic [2:0] eye_in,
   iod_step_if.scan   scan,
   output logic       done,
   output logic       err,
   output logic       oor
);

   // One extra bit so a full-line run fits
   localparam int   LEN_W   = `BITALIGN_TAP_W + 1;
   localparam tap_t TAP_MAX = tap_t'(`BITALIGN_TAP_MAX);

   scan_state_e      state;
   tap_t             tap;          // Mirror of delay line position
   tap_t             target;
   tap_t             run_start;
   tap_t             best_start;
   logic [LEN_W-1:0] run_len;
   logic [LEN_W-1:0] best_len;
   logic             pend;         // Request outstanding
   logic             abort;
   logic             skip_q;

   logic             aborting;
   logic             need_op;
   logic             issue;
   iod_op_e          op_sel;
   logic             clean;
   logic             last_tap;
   logic             best_upd;
   tap_t             cur_start;
   tap_t             best_start_n;
   logic [LEN_W-1:0] cur_len;
   logic [LEN_W-1:0] best_len_n;
   logic [LEN_W-1:0] req_len;

   // ------------------------------------------------------------------------
   // Run tracking on the sampled flags
   // ------------------------------------------------------------------------
   // Clean means no early, no late, and still in range
   assign clean    = !scan.early_seen && !scan.late_seen && !scan.oor_seen;
   assign last_tap = (tap == TAP_MAX) || scan.oor_seen;

   assign cur_start = (run_len == '0) ? tap : run_start;
   assign cur_len   = run_len + 1'b1;
   // Strictly longer, so ties keep the earlier run
   assign best_upd     = clean && (cur_len > best_len);
   assign best_len_n   = best_upd ? cur_len : best_len;
   assign best_start_n = best_upd ? cur_start : best_start;

   // Minimum window widened by the user margin
   assign req_len = LEN_W'(`BITALIGN_MIN_WINDOW) + LEN_W'(eye_in);

   // ------------------------------------------------------------------------
   // Request selection
   // ------------------------------------------------------------------------
   assign aborting = rstrt || abort;

   always_comb begin
      need_op = 1'b1;
      op_sel  = OP_CLR;
      case (state)
         LOAD:    op_sel = OP_LOAD;
         CLEAR:   op_sel = OP_CLR;
         STEP_UP: op_sel = OP_MOVE_UP;
         CENTER: begin
            op_sel  = OP_MOVE_DN;
            need_op = (tap != target);
         end
         default: need_op = 1'b0;
      endcase
   end

   // One in flight, hold stalls only new ones
   assign issue = need_op && !pend && !hold && !aborting;

   // ------------------------------------------------------------------------
   // Scanner FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge sclk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= IDLE;
         tap        <= '0;
         target     <= '0;
         run_start  <= '0;
         run_len    <= '0;
         best_start <= '0;
         best_len   <= '0;
         pend       <= 1'b0;
         abort      <= 1'b0;
         skip_q     <= 1'b0;
         done       <= 1'b0;
         err        <= 1'b0;
         oor        <= 1'b0;
         scan.req   <= 1'b0;
         scan.op    <= OP_LOAD;
      end else begin
         scan.req <= issue;
         if (issue) begin
            scan.op <= op_sel;
            pend    <= 1'b1;
         end else if (scan.ack) begin
            pend <= 1'b0;
         end

         if (aborting) begin
            if (rstrt) begin
               done <= 1'b0;
               err  <= 1'b0;
               oor  <= 1'b0;
            end
            // Let the pending operation finish first
            if (!pend || scan.ack) begin
               state <= IDLE;
               abort <= 1'b0;
            end else begin
               abort <= 1'b1;
            end
         end else begin
            case (state)
               IDLE: begin
                  if (start) begin
                     tap        <= '0;
                     run_start  <= '0;
                     run_len    <= '0;
                     best_start <= '0;
                     best_len   <= '0;
                     skip_q     <= skip;
                     done       <= 1'b0;
                     err        <= 1'b0;
                     oor        <= 1'b0;
                     state      <= LOAD;
                  end
               end
               LOAD: begin
                  if (scan.ack) begin
                     tap <= '0;
                     // Skip mode ends right after the load
                     if (skip_q) begin
                        done  <= 1'b1;
                        state <= DONE;
                     end else begin
                        state <= CLEAR;
                     end
                  end
               end
               CLEAR: begin
                  if (scan.ack) begin
                     if (clean) begin
                        run_start <= cur_start;
                        run_len   <= cur_len;
                     end else begin
                        run_len <= '0;
                     end
                     best_start <= best_start_n;
                     best_len   <= best_len_n;
                     if (last_tap) begin
                        oor <= scan.oor_seen;
                        if (best_len_n < req_len) begin
                           err   <= 1'b1;
                           state <= FAIL;
                        end else begin
                           // Middle of the run, rounded down
                           target <= best_start_n + tap_t'(best_len_n >> 1);
                           state  <= CENTER;
                        end
                     end else begin
                        state <= STEP_UP;
                     end
                  end
               end
               STEP_UP: begin
                  if (scan.ack) begin
                     tap   <= tap + 1'b1;
                     state <= CLEAR;
                  end
               end
               CENTER: begin
                  if (scan.ack) begin
                     tap <= tap - 1'b1;
                  end else if (!pend && (tap == target)) begin
                     done  <= 1'b1;
                     state <= DONE;
                  end
               end
               // DONE and FAIL wait for restart
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== source/bitalign_params.svh ====
`ifndef BITALIGN_PARAMS_SVH
`define BITALIGN_PARAMS_SVH

// ------------------------------------------------------------------------
// Delay line geometry
// ------------------------------------------------------------------------
// Bits in a tap index
`define BITALIGN_TAP_W 5
// Last usable tap of the delay line
`define BITALIGN_TAP_MAX 31

// ------------------------------------------------------------------------
// Training rules
// ------------------------------------------------------------------------
// Clean taps needed before the eye_in margin
`define BITALIGN_MIN_WINDOW 3
// Cycles from control pulse to flag sample
`define BITALIGN_SETTLE 4
// Lock qualification counter, 64 cycles
`define BITALIGN_LOCK_CNT_W 6

`endif

// ==== source/bitalign_pkg.sv ====
`include "bitalign_params.svh"

package bitalign_pkg;

   // Tap index on the input delay line
   typedef logic [`BITALIGN_TAP_W-1:0] tap_t;

   // Operations the stepper can apply to the delay controller
   typedef enum logic [1:0] {
      OP_LOAD    = 2'd0,   // Back to tap 0
      OP_CLR     = 2'd1,   // Clear early, late and range flags
      OP_MOVE_UP = 2'd2,
      OP_MOVE_DN = 2'd3
   } iod_op_e;

   // Eye scanner FSM
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      LOAD    = 3'd1,   // Reset delay to tap 0
      CLEAR   = 3'd2,   // Clear flags and sample the tap
      STEP_UP = 3'd3,   // One tap up
      CENTER  = 3'd4,   // Walk back to the window middle
      DONE    = 3'd5,
      FAIL    = 3'd6
   } scan_state_e;

endpackage

// ==== source/bitalign_start_seq.sv ====
`timescale 1ns/1ps
`include "bitalign_params.svh"

module bitalign_start_seq (
   input  logic sclk,
   input  logic arst_n,
   input  logic pll_lock,
   input  logic lp_in,
   input  logic rstrt,
   output logic start
);

   localparam int CNT_W = `BITALIGN_LOCK_CNT_W;

   logic [CNT_W-1:0] lock_cnt;
   logic             armed;
   logic             qual;
   logic             fire;

   // ------------------------------------------------------------------------
   // Qualification
   // ------------------------------------------------------------------------
   // Lane usable only with PLL locked and out of low power
   assign qual = pll_lock && !lp_in;

   // Saturated counter plus one more good cycle
   assign fire = armed && qual && !rstrt && (lock_cnt == '1);

   // ------------------------------------------------------------------------
   // Stability counter and one-shot start
   // ------------------------------------------------------------------------
   always_ff @(posedge sclk or negedge arst_n) begin
      if (!arst_n) begin
         lock_cnt <= '0;
         armed    <= 1'b1;
         start    <= 1'b0;
      end else begin
         start <= 1'b0;

         // Any glitch or restart begins the interval again
         if (!qual || rstrt) begin
            lock_cnt <= '0;
         end else if (lock_cnt != '1) begin
            lock_cnt <= lock_cnt + 1'b1;
         end

         // Rearm only on lost lock or restart
         if (!pll_lock || rstrt) begin
            armed <= 1'b1;
         end else if (fire) begin
            armed <= 1'b0;
            start <= 1'b1;
         end
      end
   end

endmodule

// ==== source/bitalign_tap_step.sv ====
`timescale 1ns/1ps
`include "bitalign_params.svh"

module bitalign_tap_step
   import bitalign_pkg::*;
(
   input  logic     sclk,
   input  logic     arst_n,
   iod_step_if.step step,
   input  logic     iod_early,
   input  logic     iod_late,
   input  logic     iod_oor,
   output logic     clr_flgs,
   output logic     load,
   output logic     dir,
   output logic     move
);

   localparam int SETTLE = `BITALIGN_SETTLE;
   localparam int CNT_W  = $clog2(SETTLE + 1);

   logic             busy;
   logic [CNT_W-1:0] settle_cnt;
   iod_op_e          op_q;
   logic             accept;
   logic             pulse;
   logic             sampled;

   // New work only when idle
   assign accept  = step.req && !busy;
   // First busy cycle carries the control pulse
   assign pulse   = busy && (settle_cnt == '0);
   // Flags have settled
   assign sampled = busy && (settle_cnt == CNT_W'(SETTLE));

   // ------------------------------------------------------------------------
   // Control pulse decode
   // ------------------------------------------------------------------------
   assign load     = pulse && (op_q == OP_LOAD);
   assign clr_flgs = pulse && (op_q == OP_CLR);
   assign move     = pulse && ((op_q == OP_MOVE_UP) || (op_q == OP_MOVE_DN));

   // ------------------------------------------------------------------------
   // Busy window and settle count
   // ------------------------------------------------------------------------
   always_ff @(posedge sclk or negedge arst_n) begin
      if (!arst_n) begin
         busy       <= 1'b0;
         settle_cnt <= '0;
         dir        <= 1'b0;
         step.ack   <= 1'b0;
      end else begin
         step.ack <= sampled;
         if (accept) begin
            busy       <= 1'b1;
            settle_cnt <= '0;
            // Direction set ahead of the move pulse and kept after it
            if (step.op == OP_MOVE_UP) begin
               dir <= 1'b1;
            end else if (step.op == OP_MOVE_DN) begin
               dir <= 1'b0;
            end
         end else if (sampled) begin
            busy       <= 1'b0;
            settle_cnt <= '0;
         end else if (busy) begin
            settle_cnt <= settle_cnt + 1'b1;
         end
      end
   end

   // Operation held for the decode
   always_ff @(posedge sclk) begin
      if (accept) begin
         op_q <= step.op;
      end
   end

   // Sticky flags captured alongside ack
   always_ff @(posedge sclk) begin
      if (sampled) begin
         step.early_seen <= iod_early;
         step.late_seen  <= iod_late;
         step.oor_seen   <= iod_oor;
      end
   end

endmodule

// ==== source/corerx_iod_bitalign.sv ====
`timescale 1ns/1ps

module corerx_iod_bitalign (
   // Clock and lane status
   input  logic       sclk,
   input  logic       arst_n,
   input  logic       pll_lock,
   input  logic       lp_in,

   // Delay controller flags
   input  logic       iod_early,
   input  logic       iod_late,
   input  logic       iod_oor,

   // Training control and status
   input  logic       bit_algn_rstrt,
   input  logic       bit_algn_hold,
   input  logic       bit_algn_skip,
   input  logic [2:0] bit_algn_eye_in,
   output logic       bit_algn_start,
   output logic       bit_algn_done,
   output logic       bit_algn_err,
   output logic       bit_algn_oor,

   // Delay controller commands
   output logic       bit_algn_clr_flgs,
   output logic       bit_algn_load,
   output logic       bit_algn_dir,
   output logic       bit_algn_move
);

   // Scanner to stepper request path
   iod_step_if step_bus ();

   // ------------------------------------------------------------------------
   // Lock qualification
   // ------------------------------------------------------------------------
   bitalign_start_seq u_start_seq (
      .sclk     (sclk),
      .arst_n   (arst_n),
      .pll_lock (pll_lock),
      .lp_in    (lp_in),
      .rstrt    (bit_algn_rstrt),
      .start    (bit_algn_start)
   );

   // ------------------------------------------------------------------------
   // Sweep and centering
   // ------------------------------------------------------------------------
   bitalign_eye_scan u_eye_scan (
      .sclk   (sclk),
      .arst_n (arst_n),
      .start  (bit_algn_start),
      .rstrt  (bit_algn_rstrt),
      .hold   (bit_algn_hold),
      .skip   (bit_algn_skip),
      .eye_in (bit_algn_eye_in),
      .scan   (step_bus.scan),
      .done   (bit_algn_done),
      .err    (bit_algn_err),
      .oor    (bit_algn_oor)
   );

   // Pulse generation toward the delay line
   bitalign_tap_step u_tap_step (
      .sclk      (sclk),
      .arst_n    (arst_n),
      .step      (step_bus.step),
      .iod_early (iod_early),
      .iod_late  (iod_late),
      .iod_oor   (iod_oor),
      .clr_flgs  (bit_algn_clr_flgs),
      .load      (bit_algn_load),
      .dir       (bit_algn_dir),
      .move      (bit_algn_move)
   );

endmodule

// ==== source/iod_step_if.sv ====
`timescale 1ns/1ps

// Request path from eye scanner to tap stepper
interface iod_step_if
   import bitalign_pkg::*;
();

   // Scanner side
   logic    req;          // Single cycle
   iod_op_e op;           // Valid with req

   // Stepper side
   logic    ack;          // Single cycle, flags valid with it
   logic    early_seen;
   logic    late_seen;
   logic    oor_seen;

   modport scan (
      output req,
      output op,
      input  ack,
      input  early_seen,
      input  late_seen,
      input  oor_seen
   );

   modport step (
      input  req,
      input  op,
      output ack,
      output early_seen,
      output late_seen,
      output oor_seen
   );

endinterface

// ==== src.f ====
+incdir+source
source/bitalign_pkg.sv
source/iod_step_if.sv
source/bitalign_start_seq.sv
source/bitalign_tap_step.sv
source/bitalign_eye_scan.sv
source/corerx_iod_bitalign.sv
verification/tb_corerx_iod_bitalign.sv

// ==== verification/tb_corerx_iod_bitalign.sv ====
`timescale 1ns/1ps
`include "bitalign_params.svh"

module tb_corerx_iod_bitalign
   import bitalign_pkg::*;
();

   localparam int TAP_MAX     = `BITALIGN_TAP_MAX;
   localparam int LOCK_CYCLES = 1 << `BITALIGN_LOCK_CNT_W;
   localparam int NO_OOR      = TAP_MAX + 1;
   localparam int NUM_CASES   = 27;
   // Worst case per training is a full sweep plus centering
   localparam int RESULT_LIMIT = LOCK_CYCLES + 3 * (TAP_MAX + 1) * (`BITALIGN_SETTLE + 4) + 400;
   localparam int WATCHDOG_NS  = NUM_CASES * (64 + 34 * 32) * 4 + 20000;

   typedef struct packed {
      tap_t tap;
      logic done;
      logic err;
      logic oor;
   } result_t;

   logic       sclk;
   logic       arst_n;
   logic       pll_lock;
   logic       lp_in;
   logic       iod_early = 1'b0;
   logic       iod_late  = 1'b0;
   logic       iod_oor   = 1'b0;
   logic       bit_algn_rstrt;
   logic       bit_algn_hold;
   logic       bit_algn_skip;
   logic [2:0] bit_algn_eye_in;
   logic       bit_algn_start;
   logic       bit_algn_done;
   logic       bit_algn_err;
   logic       bit_algn_oor;
   logic       bit_algn_clr_flgs;
   logic       bit_algn_load;
   logic       bit_algn_dir;
   logic       bit_algn_move;

   // Eye placement seen by the delay-line model
   int      eye_lo;
   int      eye_hi;
   int      oor_limit;
   tap_t    line_tap;
   result_t exp_res;
   string   case_name;
   integer  seed;

   int start_cnt = 0;
   int load_cnt = 0;
   int move_cnt = 0;
   int clr_cnt = 0;
   int start_base;
   int load_base;
   int move_base;
   int clr_base;
   int results_checked = 0;
   bit result_seen = 1'b0;
   bit hold_quiet = 1'b0;
   int value_errs = 0;
   int other_errs = 0;

   corerx_iod_bitalign dut0 (.*);

   initial begin
      sclk = 1'b0;
      forever #2 sclk = ~sclk;
   end

   // ------------------------------------------------------------------------
   // Delay-line model
   // ------------------------------------------------------------------------
   always @(posedge sclk) begin
      if (!arst_n) begin
         line_tap  <= '0;
         iod_early <= 1'b0;
         iod_late  <= 1'b0;
         iod_oor   <= 1'b0;
      end else begin
         if (bit_algn_load) begin
            line_tap <= '0;
         end else if (bit_algn_move) begin
            line_tap <= bit_algn_dir ? line_tap + 1'b1 : line_tap - 1'b1;
         end
         // Sticky until the next clear
         if (bit_algn_clr_flgs) begin
            iod_early <= 1'b0;
            iod_late  <= 1'b0;
            iod_oor   <= 1'b0;
         end else begin
            if (int'(line_tap) < eye_lo) iod_early <= 1'b1;
            if (int'(line_tap) > eye_hi) iod_late <= 1'b1;
            if (int'(line_tap) >= oor_limit) iod_oor <= 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Reference and compare tasks
   // ------------------------------------------------------------------------
   function automatic result_t expected_result(int lo, int hi, int lim, int ein, bit skp);
      result_t r;
      int last;
      int t;
      int run_s;
      int run_l;
      int best_s;
      int best_l;
      r = '0;
      if (skp) begin
         r.done = 1'b1;
         return r;
      end
      // Sweep stops at the range flag or the top tap
      last   = (lim <= TAP_MAX) ? lim : TAP_MAX;
      r.oor  = (lim <= TAP_MAX);
      run_s  = 0;
      run_l  = 0;
      best_s = 0;
      best_l = 0;
      for (t = 0; t <= last; t++) begin
         if (t >= lo && t <= hi && t < lim) begin
            if (run_l == 0) run_s = t;
            run_l++;
            // Earlier run wins a tie
            if (run_l > best_l) begin
               best_l = run_l;
               best_s = run_s;
            end
         end else begin
            run_l = 0;
         end
      end
      if (best_l < `BITALIGN_MIN_WINDOW + ein) begin
         r.err = 1'b1;
         r.tap = tap_t'(last);
      end else begin
         r.done = 1'b1;
         r.tap  = tap_t'(best_s + best_l / 2);
      end
      return r;
   endfunction

   task automatic check_tap(input tap_t got, input tap_t exp, input string what);
      if (got !== exp) begin
         value_errs++;
         $display("FAILED @%0t: %s final tap %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input logic [2:0] got, input logic [2:0] exp, input string what);
      if (got !== exp) begin
         value_errs++;
         $display("FAILED @%0t: %s done/err/oor %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         value_errs++;
         $display("FAILED @%0t: %s count %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // Pulse counters and hold monitor
   always @(negedge sclk) begin
      if (bit_algn_start) start_cnt++;
      if (bit_algn_load) load_cnt++;
      if (bit_algn_move) move_cnt++;
      if (bit_algn_clr_flgs) clr_cnt++;
      if (hold_quiet && (bit_algn_load || bit_algn_move || bit_algn_clr_flgs)) begin
         other_errs++;
         $display("Control pulse on the delay line at %0t while hold was high", $time);
      end
   end

   // Result compare on the rising edge of done or err
   always @(negedge sclk) begin
      if ((bit_algn_done || bit_algn_err) && !result_seen) begin
         result_seen = 1'b1;
         check_status({bit_algn_done, bit_algn_err, bit_algn_oor},
                      {exp_res.done, exp_res.err, exp_res.oor}, case_name);
         check_tap(line_tap, exp_res.tap, case_name);
         results_checked++;
      end else if (!bit_algn_done && !bit_algn_err) begin
         result_seen = 1'b0;
      end
   end

   // ------------------------------------------------------------------------
   // Scenario tasks
   // ------------------------------------------------------------------------
   task automatic drive_case(input int lo, input int hi, input int lim, input int ein,
                             input bit skp, input string name);
      @(posedge sclk);
      eye_lo          <= lo;
      eye_hi          <= hi;
      oor_limit       <= lim;
      bit_algn_eye_in <= ein[2:0];
      bit_algn_skip   <= skp;
      exp_res          = expected_result(lo, hi, lim, ein, skp);
      case_name        = name;
      start_base       = start_cnt;
      load_base        = load_cnt;
      move_base        = move_cnt;
      clr_base         = clr_cnt;
   endtask

   task automatic restart_training();
      @(posedge sclk);
      bit_algn_rstrt <= 1'b1;
      @(posedge sclk);
      bit_algn_rstrt <= 1'b0;
      @(negedge sclk);
      check_status({bit_algn_done, bit_algn_err, bit_algn_oor}, 3'b000, "after restart");
   endtask

   task automatic qualify_lock();
      int n;
      // Lane out of low power but PLL still unlocked
      lp_in <= 1'b0;
      repeat (LOCK_CYCLES + 16) @(posedge sclk);
      check_count(start_cnt - start_base, 0, "start pulses without lock");
      // PLL locked with the lane back in low power
      pll_lock <= 1'b1;
      lp_in    <= 1'b1;
      repeat (LOCK_CYCLES + 16) @(posedge sclk);
      check_count(start_cnt - start_base, 0, "start pulses in low power");
      lp_in <= 1'b0;
      n = 0;
      @(negedge sclk);
      while (!bit_algn_start && n < RESULT_LIMIT) begin
         n++;
         @(negedge sclk);
      end
      if (!bit_algn_start) begin
         other_errs++;
         $display("No start pulse after lock qualification");
      end else if (n < LOCK_CYCLES) begin
         value_errs++;
         $display("FAILED @%0t: start after %0d qualified cycles, too early", $time, n);
      end
      check_count((load_cnt - load_base) + (move_cnt - move_base) + (clr_cnt - clr_base),
                  0, "control pulses before start");
   endtask

   task automatic apply_hold(input int delay);
      int n;
      n = 0;
      while (start_cnt == start_base && n < RESULT_LIMIT) begin
         n++;
         @(negedge sclk);
      end
      repeat (delay) @(posedge sclk);
      bit_algn_hold <= 1'b1;
      // Outstanding request may still pulse in the first cycles
      repeat (3) @(posedge sclk);
      hold_quiet = 1'b1;
      repeat (47) @(posedge sclk);
      hold_quiet = 1'b0;
      bit_algn_hold <= 1'b0;
   endtask

   task automatic wait_result();
      int seen0;
      int n;
      seen0 = results_checked;
      n = 0;
      while (results_checked == seen0 && n < RESULT_LIMIT) begin
         n++;
         @(negedge sclk);
      end
      if (results_checked == seen0) begin
         other_errs++;
         $display("Timeout waiting for done or err in %s, scanner in %s",
                  case_name, dut0.u_eye_scan.state.name());
      end
      check_count(start_cnt - start_base, 1, {case_name, " start"});
      check_count(load_cnt - load_base, 1, {case_name, " load"});
      if (bit_algn_skip) check_count(move_cnt - move_base, 0, {case_name, " move"});
   endtask

   task automatic run_case(input int lo, input int hi, input int lim, input int ein,
                           input bit skp, input int hold_after, input string name);
      drive_case(lo, hi, lim, ein, skp, name);
      restart_training();
      if (hold_after > 0) apply_hold(hold_after);
      wait_result();
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      int i;
      int ein;
      int len;
      int lo;
      arst_n          = 1'b0;
      pll_lock        = 1'b0;
      lp_in           = 1'b1;
      bit_algn_rstrt  = 1'b0;
      bit_algn_hold   = 1'b0;
      bit_algn_skip   = 1'b0;
      bit_algn_eye_in = 3'd0;
      eye_lo          = 0;
      eye_hi          = TAP_MAX;
      oor_limit       = NO_OOR;
      seed            = 32'heeff29f7;
      repeat (3) @(posedge sclk);
      arst_n <= 1'b1;

      // First training comes straight from lock qualification
      drive_case(6, 17, NO_OOR, 0, 1'b0, "first lock");
      qualify_lock();
      wait_result();

      // Random eyes that always meet the margin
      for (i = 0; i < 20; i++) begin
         ein = $unsigned($random(seed)) % 4;
         len = `BITALIGN_MIN_WINDOW + ein + $unsigned($random(seed)) % 8;
         lo  = $unsigned($random(seed)) % (TAP_MAX + 2 - len);
         run_case(lo, lo + len - 1, NO_OOR, ein, 1'b0, 0, $sformatf("random eye %0d", i));
      end

      // Same narrow eye fails with margin and passes without
      run_case(10, 14, NO_OOR, 3, 1'b0, 0, "narrow eye with margin");
      run_case(10, 14, NO_OOR, 0, 1'b0, 0, "narrow eye no margin");
      // Range flag cuts the sweep short
      run_case(5, 25, 20, 0, 1'b0, 0, "out of range");
      run_case(18, 25, 20, 0, 1'b0, 0, "out of range narrow");
      run_case(8, 20, NO_OOR, 0, 1'b1, 0, "skip");
      run_case(4, 22, NO_OOR, 1, 1'b0, 150, "hold mid sweep");

      repeat (5) @(posedge sclk);
      $display("Errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog sized from the full set of trainings
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all trainings finished");
      $display("Simulation FAILED");
      $finish;
   end

endmodule
